// ==== rtl/decode_pkg.sv ====
// Shared encodings, field positions and stage structs for the decoder pipeline; compile it first
`default_nettype none

package decode_pkg;

	// ==================================================
	// Instruction format
	// ==================================================

	localparam int OPC_LSB = 26;
	localparam int OPC_W = 6;
	localparam int RT_LSB = 21;
	localparam int RA_LSB = 16;
	localparam int RB_LSB = 11;
	localparam int REG_W = 5;
	localparam int IMM_W = 16;

	// Payload bits carried by an EXI prefix (instruction bits 25..0)
	localparam int EXT_W = 26;

	// Widest value the output bundle can carry
	localparam int VALUE_W_MAX = 64;

	typedef enum logic [5:0] {
		ALU_RR = 6'h02,
		ADDI   = 6'h04,
		ANDI   = 6'h08,
		ORI    = 6'h09,
		LDB    = 6'h10,
		LDBU   = 6'h11,
		LDW    = 6'h12,
		LDWU   = 6'h13,
		LDO    = 6'h16,
		STB    = 6'h18,
		STW    = 6'h19,
		STO    = 6'h1b,
		JMP    = 6'h20,
		JEQ    = 6'h26,
		EXI    = 6'h30
	} opcode_e;

	typedef enum logic [1:0] {
		BYT   = 2'd0,
		WYDE  = 2'd1,
		TETRA = 2'd2,
		OCTA  = 2'd3
	} memsz_e;

	// ==================================================
	// Inter-stage bundles
	// ==================================================

	typedef struct packed {
		logic [31:0]      instr;
		logic             ext_valid;
		logic [EXT_W-1:0] ext;
	} merged_t;

	typedef struct packed {
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] rc;
		logic [REG_W-1:0] rt;
		logic             rfwr;
		logic             ld;
		logic             ldz;
		logic             st;
		logic             jmp;
		logic             jxx;
		logic             illegal;
		memsz_e           memsz;
	} ctrl_t;

	typedef struct packed {
		ctrl_t            ctrl;
		opcode_e          opcode;
		logic [IMM_W-1:0] imm16;
		logic [EXT_W-1:0] low26;
		logic             ext_valid;
		logic [EXT_W-1:0] ext;
	} stage2_t;

	// imm and target are zero above the VALUE_W of the top level
	typedef struct packed {
		ctrl_t                  ctrl;
		logic [VALUE_W_MAX-1:0] imm;
		logic [VALUE_W_MAX-1:0] target;
	} decoded_t;

endpackage

`default_nettype wire

// ==== rtl/prefix_merge.sv ====
// Pipeline stage 1: holds EXI prefix payloads and attaches them to the next instruction
`default_nettype none

module prefix_merge
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [31:0]              instr,
	output logic                     out_valid,
	input  logic                     out_ready,
	output decode_pkg::merged_t      merged
);

	logic                         accept;
	logic                         is_exi;
	logic                         pfx_valid;
	logic [decode_pkg::EXT_W-1:0] pfx;

	// Stage register is free, or its item leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;
	assign is_exi = decode_pkg::opcode_e'(instr[decode_pkg::OPC_LSB +: decode_pkg::OPC_W])
		== decode_pkg::EXI;

	// ==================================================
	// Held prefix
	// ==================================================

	// A second EXI simply overwrites the first one
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pfx_valid <= 1'b0;
		else if (accept)
			pfx_valid <= is_exi;
	end

	always_ff @(posedge clk)
	begin
		if (accept && is_exi)
			pfx <= instr[decode_pkg::EXT_W-1:0];
	end

	// ==================================================
	// Stage register
	// ==================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (accept && !is_exi)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept && !is_exi)
		begin
			merged.instr <= instr;
			merged.ext_valid <= pfx_valid;
			// Keep the payload clean when no prefix is attached
			merged.ext <= pfx_valid ? pfx : '0;
		end
	end

	// Prefixes are consumed here and never travel down the pipe
	a_no_exi_out: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> decode_pkg::opcode_e'(merged.instr[decode_pkg::OPC_LSB +: decode_pkg::OPC_W])
			!= decode_pkg::EXI);

endmodule

`default_nettype wire

// ==== rtl/field_decode.sv ====
// Pipeline stage 2: turns the opcode into control flags and picks the register numbers
`default_nettype none

module field_decode
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  decode_pkg::merged_t      merged,
	output logic                     out_valid,
	input  logic                     out_ready,
	output decode_pkg::stage2_t      stage
);

	logic                         accept;
	decode_pkg::opcode_e          op;
	logic [decode_pkg::REG_W-1:0] f_rt;
	logic [decode_pkg::REG_W-1:0] f_ra;
	logic [decode_pkg::REG_W-1:0] f_rb;
	decode_pkg::ctrl_t            ctrl;

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	assign op = decode_pkg::opcode_e'(merged.instr[decode_pkg::OPC_LSB +: decode_pkg::OPC_W]);
	assign f_rt = merged.instr[decode_pkg::RT_LSB +: decode_pkg::REG_W];
	assign f_ra = merged.instr[decode_pkg::RA_LSB +: decode_pkg::REG_W];
	assign f_rb = merged.instr[decode_pkg::RB_LSB +: decode_pkg::REG_W];

	// ==================================================
	// Opcode classification
	// ==================================================

	always_comb
	begin
		ctrl = '0;
		ctrl.ra = f_ra;
		ctrl.rb = f_rb;
		case (op)
		decode_pkg::ALU_RR:
			ctrl.rfwr = 1'b1;
		decode_pkg::ADDI, decode_pkg::ANDI, decode_pkg::ORI:
		begin
			ctrl.rfwr = 1'b1;
			ctrl.rb = '0;
		end
		decode_pkg::LDB, decode_pkg::LDBU, decode_pkg::LDW, decode_pkg::LDWU, decode_pkg::LDO:
		begin
			ctrl.rfwr = 1'b1;
			ctrl.ld = 1'b1;
			ctrl.ldz = (op == decode_pkg::LDBU) || (op == decode_pkg::LDWU);
			ctrl.rb = '0;
		end
		decode_pkg::STB, decode_pkg::STW, decode_pkg::STO:
		begin
			ctrl.st = 1'b1;
			// Store data register sits in the rt field
			ctrl.rc = f_rt;
			ctrl.rb = '0;
		end
		decode_pkg::JMP:
		begin
			ctrl.jmp = 1'b1;
			ctrl.ra = '0;
			ctrl.rb = '0;
		end
		decode_pkg::JEQ:
			ctrl.jxx = 1'b1;
		decode_pkg::EXI:
			;
		default:
		begin
			ctrl = '0;
			ctrl.illegal = 1'b1;
		end
		endcase

		// Access size, with illegal words left at zero
		case (op)
		decode_pkg::LDB, decode_pkg::LDBU, decode_pkg::STB:
			ctrl.memsz = decode_pkg::BYT;
		decode_pkg::LDW, decode_pkg::LDWU, decode_pkg::STW:
			ctrl.memsz = decode_pkg::WYDE;
		default:
			ctrl.memsz = ctrl.illegal ? decode_pkg::BYT : decode_pkg::OCTA;
		endcase

		ctrl.rt = ctrl.rfwr ? f_rt : '0;
	end

	// ==================================================
	// Stage register
	// ==================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			stage.ctrl <= ctrl;
			stage.opcode <= op;
			stage.imm16 <= merged.instr[decode_pkg::IMM_W-1:0];
			stage.low26 <= merged.instr[decode_pkg::EXT_W-1:0];
			stage.ext_valid <= merged.ext_valid;
			stage.ext <= merged.ext;
		end
	end

	a_hold_stage: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(stage));

endmodule

`default_nettype wire

// ==== rtl/imm_build.sv ====
// Pipeline stage 3: builds the padded immediate and the branch or jump target
`default_nettype none

module imm_build
#(
	parameter int VALUE_W = 64
)
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  decode_pkg::stage2_t      stage,
	output logic                     out_valid,
	input  logic                     out_ready,
	output decode_pkg::decoded_t     deco
);

	localparam int VMAX = decode_pkg::VALUE_W_MAX;
	localparam int IW = decode_pkg::IMM_W;
	// Prefix payload stacked above imm16
	localparam int XW = decode_pkg::EXT_W + decode_pkg::IMM_W;

	logic            accept;
	logic            has_imm;
	logic [XW-1:0]   ext_imm;
	logic [VMAX-1:0] imm_full;
	logic [VMAX-1:0] tgt_full;
	logic [VMAX-1:0] imm_z;
	logic [VMAX-1:0] tgt_z;

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;
	assign ext_imm = {stage.ext, stage.imm16};

	// ==================================================
	// Immediate and target
	// ==================================================

	always_comb
	begin
		has_imm = 1'b1;
		case (stage.opcode)
		decode_pkg::ANDI:
			imm_full = {{(VMAX-IW){1'b1}}, stage.imm16};
		decode_pkg::ORI:
			imm_full = {{(VMAX-IW){1'b0}}, stage.imm16};
		decode_pkg::ADDI,
		decode_pkg::LDB, decode_pkg::LDBU, decode_pkg::LDW, decode_pkg::LDWU, decode_pkg::LDO,
		decode_pkg::STB, decode_pkg::STW, decode_pkg::STO:
			imm_full = {{(VMAX-IW){stage.imm16[IW-1]}}, stage.imm16};
		default:
		begin
			has_imm = 1'b0;
			imm_full = '0;
		end
		endcase

		// A prefix always sign-extends regardless of the opcode's own padding
		if (has_imm && stage.ext_valid)
			imm_full = {{(VMAX-XW){ext_imm[XW-1]}}, ext_imm};

		case (stage.opcode)
		decode_pkg::JEQ:
			tgt_full = {{(VMAX-12){stage.low26[10]}}, stage.low26[10:0], 1'b0};
		decode_pkg::JMP:
			tgt_full = {{(VMAX-27){stage.low26[25]}}, stage.low26, 1'b0};
		default:
			tgt_full = '0;
		endcase

		// Only the low VALUE_W bits carry meaning
		imm_z = '0;
		tgt_z = '0;
		imm_z[VALUE_W-1:0] = imm_full[VALUE_W-1:0];
		tgt_z[VALUE_W-1:0] = tgt_full[VALUE_W-1:0];
	end

	// ==================================================
	// Stage register
	// ==================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			deco.ctrl <= stage.ctrl;
			deco.imm <= imm_z;
			deco.target <= tgt_z;
		end
	end

	// Illegal words carry neither an immediate nor a target
	a_illegal_zero: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && deco.ctrl.illegal |-> deco.imm == '0 && deco.target == '0);

endmodule

`default_nettype wire

// ==== rtl/decode_top.sv ====
// Decoder top level: chains the prefix, field and immediate stages behind one stream port
`default_nettype none

module decode_top
#(
	parameter int VALUE_W = 64
)
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [31:0]              instr,
	output logic                     out_valid,
	input  logic                     out_ready,
	output decode_pkg::decoded_t     deco
);

	// Stage 1 to stage 2
	logic                m_valid;
	logic                m_ready;
	decode_pkg::merged_t merged;

	// Stage 2 to stage 3
	logic                s_valid;
	logic                s_ready;
	decode_pkg::stage2_t stage;

	prefix_merge prefix_merge_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.instr     (instr),
		.out_valid (m_valid),
		.out_ready (m_ready),
		.merged    (merged)
	);

	field_decode field_decode_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (m_valid),
		.in_ready  (m_ready),
		.merged    (merged),
		.out_valid (s_valid),
		.out_ready (s_ready),
		.stage     (stage)
	);

	imm_build #(
		.VALUE_W (VALUE_W)
	) imm_build_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (s_valid),
		.in_ready  (s_ready),
		.stage     (stage),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.deco      (deco)
	);

endmodule

`default_nettype wire

// ==== tb/decode_model.svh ====
// Reference decoder for the testbench; include it ahead of the testbench module
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH
`default_nettype none

// Sign-extend the low bits of v to 64 bits
function automatic logic [63:0] sign_extend(input logic [63:0] v, input int bits);
	logic signed [63:0] t;
	t = v << (64 - bits);
	t = t >>> (64 - bits);
	return t;
endfunction

// Expected bundle for one instruction word and the prefix pending before it
function automatic decode_pkg::decoded_t decode_model(input logic [31:0] w,
	input logic pfx_valid, input logic [25:0] pfx, input int value_w);
	decode_pkg::decoded_t d;
	logic [5:0]           op;
	logic [15:0]          imm16;
	logic [63:0]          mask;
	logic                 is_ld;
	logic                 is_st;
	logic                 is_ari;
	op = w[31:26];
	imm16 = w[15:0];
	is_ld = op inside {decode_pkg::LDB, decode_pkg::LDBU, decode_pkg::LDW,
		decode_pkg::LDWU, decode_pkg::LDO};
	is_st = op inside {decode_pkg::STB, decode_pkg::STW, decode_pkg::STO};
	is_ari = op inside {decode_pkg::ADDI, decode_pkg::ANDI, decode_pkg::ORI};
	d = '0;

	// Unlisted opcodes raise illegal and nothing else
	if (!(is_ld || is_st || is_ari || op == decode_pkg::ALU_RR
		|| op == decode_pkg::JMP || op == decode_pkg::JEQ))
	begin
		d.ctrl.illegal = 1'b1;
		return d;
	end

	d.ctrl.rfwr = is_ari || is_ld || op == decode_pkg::ALU_RR;
	d.ctrl.ld = is_ld;
	d.ctrl.ldz = op == decode_pkg::LDBU || op == decode_pkg::LDWU;
	d.ctrl.st = is_st;
	d.ctrl.jmp = op == decode_pkg::JMP;
	d.ctrl.jxx = op == decode_pkg::JEQ;
	d.ctrl.ra = d.ctrl.jmp ? 5'd0 : w[20:16];
	d.ctrl.rb = (op == decode_pkg::ALU_RR || op == decode_pkg::JEQ) ? w[15:11] : 5'd0;
	d.ctrl.rt = d.ctrl.rfwr ? w[25:21] : 5'd0;
	d.ctrl.rc = is_st ? w[25:21] : 5'd0;
	if (op inside {decode_pkg::LDB, decode_pkg::LDBU, decode_pkg::STB})
		d.ctrl.memsz = decode_pkg::BYT;
	else if (op inside {decode_pkg::LDW, decode_pkg::LDWU, decode_pkg::STW})
		d.ctrl.memsz = decode_pkg::WYDE;
	else
		d.ctrl.memsz = decode_pkg::OCTA;

	if (is_ari || is_ld || is_st)
	begin
		if (pfx_valid)
			d.imm = sign_extend({22'd0, pfx, imm16}, 42);
		else if (op == decode_pkg::ANDI)
			d.imm = {48'hffff_ffff_ffff, imm16};
		else if (op == decode_pkg::ORI)
			d.imm = {48'd0, imm16};
		else
			d.imm = sign_extend({48'd0, imm16}, 16);
	end
	if (d.ctrl.jxx)
		d.target = sign_extend({53'd0, w[10:0]}, 11) << 1;
	if (d.ctrl.jmp)
		d.target = sign_extend({38'd0, w[25:0]}, 26) << 1;

	mask = (value_w >= 64) ? '1 : ((64'd1 << value_w) - 64'd1);
	d.imm &= mask;
	d.target &= mask;
	return d;
endfunction

`default_nettype wire
`endif

// ==== tb/decode_tb.sv ====
// Testbench for decode_top: LFSR instruction stream checked against the reference model
`include "decode_model.svh"
`default_nettype none

module decode_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          VALUE_W = 64;
	localparam int          ACCEPT_LIMIT = 200;
	localparam int          DRAIN_LIMIT = 2000;
	localparam logic [31:0] SEED = 32'h1376;

	logic                 clk;
	logic                 arst_n;
	logic                 in_valid;
	logic                 in_ready;
	logic [31:0]          instr;
	logic                 out_valid;
	logic                 out_ready;
	decode_pkg::decoded_t deco;

	logic [31:0]          stim_state;
	logic [31:0]          bp_state;
	logic                 bp_mode;
	logic                 timed_out;
	// Prefix the model believes the DUT is holding
	logic                 pfx_valid;
	logic [25:0]          pfx;
	int                   edge_count = 0;
	int                   last_accept_edge;
	int                   errors;
	int                   checks;
	int                   out_count;
	int                   sent_count;
	int                   tests_run;
	int                   err_mark;
	int                   out_mark;
	int                   sent_mark;
	decode_pkg::decoded_t exp_q[$];
	decode_pkg::decoded_t want;

	decode_top #(
		.VALUE_W (VALUE_W)
	) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.instr     (instr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.deco      (deco)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		edge_count <= edge_count + 1;

	// ==================================================
	// Random numbers
	// ==================================================

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], stim_state[0]};
			stim_state = lfsr_next(stim_state);
		end
		return r;
	endfunction

	// Immediate opcodes first, then flow, ALU_RR and EXI
	function automatic logic [5:0] opcode_at(input int idx);
		case (idx)
		0: return decode_pkg::ADDI;
		1: return decode_pkg::ANDI;
		2: return decode_pkg::ORI;
		3: return decode_pkg::LDB;
		4: return decode_pkg::LDBU;
		5: return decode_pkg::LDW;
		6: return decode_pkg::LDWU;
		7: return decode_pkg::LDO;
		8: return decode_pkg::STB;
		9: return decode_pkg::STW;
		10: return decode_pkg::STO;
		11: return decode_pkg::JMP;
		12: return decode_pkg::JEQ;
		13: return decode_pkg::ALU_RR;
		default: return decode_pkg::EXI;
		endcase
	endfunction

	// Opcode from the first kinds entries, or about 10 percent raw when with_illegal
	function automatic logic [31:0] random_word(input int kinds, input bit with_illegal);
		logic [31:0] sel;
		logic [31:0] low;
		logic [5:0]  op;
		sel = rand_bits(7);
		op = opcode_at(int'(rand_bits(4)) % kinds);
		if (with_illegal && sel >= 32'd115)
		begin
			sel = rand_bits(6);
			op = sel[5:0];
		end
		low = rand_bits(26);
		return {op, low[25:0]};
	endfunction

	function automatic logic [31:0] exi_word();
		logic [31:0] r;
		logic [5:0]  op;
		op = decode_pkg::EXI;
		r = rand_bits(26);
		return {op, r[25:0]};
	endfunction

	// Consumer side stalls at random while bp_mode is set
	always @(posedge clk)
	begin
		#1;
		if (bp_mode)
		begin
			out_ready = bp_state[0];
			bp_state = lfsr_next(bp_state);
		end
		else
			out_ready = 1'b1;
	end

	// ==================================================
	// Checks
	// ==================================================

	task automatic check_field(input string name, input logic [63:0] got,
		input logic [63:0] exp_val);
		checks++;
		assert (got == exp_val)
		else
		begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp_val);
			errors++;
		end
	endtask

	task automatic compare_bundle(input decode_pkg::decoded_t got,
		input decode_pkg::decoded_t exp_b);
		check_field("ra", 64'(got.ctrl.ra), 64'(exp_b.ctrl.ra));
		check_field("rb", 64'(got.ctrl.rb), 64'(exp_b.ctrl.rb));
		check_field("rc", 64'(got.ctrl.rc), 64'(exp_b.ctrl.rc));
		check_field("rt", 64'(got.ctrl.rt), 64'(exp_b.ctrl.rt));
		check_field("rfwr", 64'(got.ctrl.rfwr), 64'(exp_b.ctrl.rfwr));
		check_field("ld", 64'(got.ctrl.ld), 64'(exp_b.ctrl.ld));
		check_field("ldz", 64'(got.ctrl.ldz), 64'(exp_b.ctrl.ldz));
		check_field("st", 64'(got.ctrl.st), 64'(exp_b.ctrl.st));
		check_field("jmp", 64'(got.ctrl.jmp), 64'(exp_b.ctrl.jmp));
		check_field("jxx", 64'(got.ctrl.jxx), 64'(exp_b.ctrl.jxx));
		check_field("illegal", 64'(got.ctrl.illegal), 64'(exp_b.ctrl.illegal));
		check_field("memsz", 64'(got.ctrl.memsz), 64'(exp_b.ctrl.memsz));
		check_field("imm", got.imm, exp_b.imm);
		check_field("target", got.target, exp_b.target);
	endtask

	// Outputs are stable at the falling edge; a transfer then completes at the next rise
	always @(negedge clk)
	begin
		if (arst_n && out_valid && out_ready)
		begin
			out_count++;
			assert (exp_q.size() != 0)
			else
			begin
				$display("Unexpected output at %0t ns: no instruction was waiting for it", $time);
				errors++;
			end
			if (exp_q.size() != 0)
			begin
				want = exp_q.pop_front();
				compare_bundle(deco, want);
			end
		end
	end

	// ==================================================
	// Driver
	// ==================================================

	task automatic send_word(input logic [31:0] w);
		int waited;
		if (timed_out)
			return;
		waited = 0;
		in_valid = 1'b1;
		instr = w;
		@(negedge clk);
		while (!in_ready && waited < ACCEPT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (in_ready)
			last_accept_edge = edge_count + 1;
		else
		begin
			$display("Timeout: instruction %h was never accepted", w);
			timed_out = 1'b1;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		if (timed_out)
			return;
		if (w[31:26] == decode_pkg::EXI)
		begin
			pfx_valid = 1'b1;
			pfx = w[25:0];
		end
		else
		begin
			exp_q.push_back(decode_model(w, pfx_valid, pfx, VALUE_W));
			pfx_valid = 1'b0;
			sent_count++;
		end
	endtask

	task automatic wait_drain();
		int waited;
		if (timed_out)
			return;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Timeout: %0d expected outputs never arrived", exp_q.size());
			timed_out = 1'b1;
		end
		// A few idle cycles expose any duplicated output
		repeat (4) @(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic begin_test();
		err_mark = errors;
		out_mark = out_count;
		sent_mark = sent_count;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		checks++;
		assert (out_count - out_mark == sent_count - sent_mark)
		else
		begin
			$display("Mismatch at %0t ns: %0d outputs for %0d instructions", $time,
				out_count - out_mark, sent_count - sent_mark);
			errors++;
		end
		$display("Test %0d %s: %0d outputs, %0d errors", tests_run, name,
			out_count - out_mark, errors - err_mark);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial
	begin
		logic [31:0] w;
		int          waited;
		int          latency;
		arst_n = 1'b0;
		in_valid = 1'b0;
		instr = '0;
		out_ready = 1'b1;
		bp_mode = 1'b0;
		timed_out = 1'b0;
		pfx_valid = 1'b0;
		pfx = '0;
		stim_state = SEED;
		bp_state = SEED;
		errors = 0;
		checks = 0;
		out_count = 0;
		sent_count = 0;
		tests_run = 0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		begin_test();
		for (int i = 0; i < 300 && !timed_out; i++)
			send_word(random_word(15, 1'b1));
		wait_drain();
		report_test("control and registers");

		begin_test();
		for (int i = 0; i < 150 && !timed_out; i++)
			send_word(random_word(13, 1'b0));
		wait_drain();
		report_test("immediates and targets");

		// Prefixed, plain, then doubly prefixed copies of the same word
		begin_test();
		for (int i = 0; i < 40 && !timed_out; i++)
		begin
			w = random_word(11, 1'b0);
			send_word(exi_word());
			send_word(w);
			send_word(w);
			send_word(exi_word());
			send_word(exi_word());
			send_word(w);
		end
		wait_drain();
		report_test("prefix merging");

		begin_test();
		for (int i = 0; i < 8 && !timed_out; i++)
		begin
			wait_drain();
			send_word(random_word(14, 1'b0));
			waited = 0;
			@(negedge clk);
			while (!out_valid && waited < 10)
			begin
				@(negedge clk);
				waited++;
			end
			if (!out_valid)
			begin
				$display("Timeout: no output after an accepted instruction");
				timed_out = 1'b1;
			end
			else
			begin
				// The output is taken at the rising edge after this falling edge
				latency = edge_count + 1 - last_accept_edge;
				checks++;
				assert (latency == 3)
				else
				begin
					$display("Mismatch at %0t ns: latency %0d cycles, expected 3", $time, latency);
					errors++;
				end
			end
			@(posedge clk);
			#1;
		end
		wait_drain();
		report_test("latency");

		begin_test();
		@(negedge clk);
		bp_mode = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < 300 && !timed_out; i++)
			send_word(random_word(15, 1'b1));
		@(negedge clk);
		bp_mode = 1'b0;
		@(posedge clk);
		#1;
		wait_drain();
		report_test("back-pressure and order");

		$display("Summary: %0d tests, %0d checks, %0d outputs, %0d errors",
			tests_run, checks, out_count, errors);
		if (errors == 0 && !timed_out)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
rtl/decode_pkg.sv
rtl/prefix_merge.sv
rtl/field_decode.sv
rtl/imm_build.sv
rtl/decode_top.sv
tb/decode_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module decode_tb -f list.f -o decode_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/decode_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
